//--- src.f
+incdir+rtl
rtl/host_pkg.sv
rtl/cpu_pkg.sv
rtl/mmio_regs.sv
rtl/addr_tr_unit.sv
rtl/mem_ctrl.sv
rtl/afu.sv
test/afu_tb.sv

//--- test/afu_tb.sv
// AFU testbench; host memory covers 1024 lines, so bases and offsets are kept below 64 KiB
`timescale 1ns/1ps
`default_nettype none

`include "afu_settings.svh"

module afu_tb;

   localparam int MEM_LINES      = 1024;
   localparam int TIMEOUT_CYCLES = 3000;

   logic                     clk;
   logic                     rst_n;
   logic                     mmio_wr_en;
   logic [15:0]              mmio_wr_addr;
   logic [63:0]              mmio_wr_data;
   logic                     mmio_rd_en;
   logic [15:0]              mmio_rd_addr;
   wire  [63:0]              mmio_rd_data;
   wire                      mmio_rd_valid;
   cpu_pkg::mem_op_t         op;
   logic [63:0]              cpu_addr;
   logic [31:0]              cpu_wdata;
   wire                      ready;
   wire  [31:0]              cpu_rdata;
   wire                      rd_valid;
   wire                      tx_done;
   logic [511:0]             dma_rd_data;
   logic                     dma_empty;
   logic                     dma_full;
   logic                     dma_wr_done;
   wire  [63:0]              dma_addr;
   wire                      dma_rd_go;
   wire                      dma_rd_en;
   wire                      dma_wr_go;
   wire                      dma_wr_en;
   wire  [511:0]             dma_wr_data;

   // Host memory of the DMA model and the segment bases software programmed
   logic [511:0] host_mem [0:MEM_LINES-1];
   logic [63:0]  seg_base [0:3];
   logic [63:0]  exp_addr;
   logic [511:0] wr_line_seen;
   logic [511:0] line;
   logic [63:0]  rd_word;
   logic [61:0]  off;
   integer       seed;
   int           cycle_count = 0;
   int           rd_go_cnt;
   int           rd_en_cnt;
   int           wr_go_cnt;
   int           wr_en_cnt;
   int           tx_done_cnt;
   int           empty_wait;
   int           full_wait;
   int           done_wait;
   int           round;
   int           s;
   int           i;
   int           k;
   bit           go_written;
   bit           busy;
   bit           op_is_write;
   bit           rd_go_seen;
   bit           rd_en_seen;
   bit           wr_go_seen;
   bit           wr_en_seen;
   bit           rd_pending;
   bit           wr_pending;
   bit           done_pending;

   afu dut0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .mmio_wr_en    (mmio_wr_en),
      .mmio_wr_addr  (mmio_wr_addr),
      .mmio_wr_data  (mmio_wr_data),
      .mmio_rd_en    (mmio_rd_en),
      .mmio_rd_addr  (mmio_rd_addr),
      .mmio_rd_data  (mmio_rd_data),
      .mmio_rd_valid (mmio_rd_valid),
      .op            (op),
      .cpu_addr      (cpu_addr),
      .cpu_wdata     (cpu_wdata),
      .ready         (ready),
      .cpu_rdata     (cpu_rdata),
      .rd_valid      (rd_valid),
      .tx_done       (tx_done),
      .dma_rd_data   (dma_rd_data),
      .dma_empty     (dma_empty),
      .dma_full      (dma_full),
      .dma_wr_done   (dma_wr_done),
      .dma_addr      (dma_addr),
      .dma_rd_go     (dma_rd_go),
      .dma_rd_en     (dma_rd_en),
      .dma_wr_go     (dma_wr_go),
      .dma_wr_en     (dma_wr_en),
      .dma_wr_data   (dma_wr_data)
   );

   always #4 clk = ~clk;

   // ====================
   // Failure reporting
   // ====================

   task automatic report_mismatch(input string name, input logic [511:0] exp,
                                  input logic [511:0] got);
      $display("Mismatch %s expected %0h actual %0h", name, exp, got);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic report_violation(input string what);
      $display("Error: %s", what);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   // The DMA model maps a host byte address onto its line array
   function automatic int line_index(input logic [63:0] addr);
      return int'((addr >> 6) % MEM_LINES);
   endfunction

   // Expected host address computed from the bases the testbench wrote
   function automatic logic [63:0] xlate(input logic [1:0] seg, input logic [61:0] ofs);
      return seg_base[seg] + {2'b00, ofs};
   endfunction

   // ====================
   // MMIO access
   // ====================

   task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
      @(negedge clk);
      mmio_wr_en   = 1'b1;
      mmio_wr_addr = addr;
      mmio_wr_data = data;
      @(negedge clk);
      mmio_wr_en = 1'b0;
   endtask

   // Response is registered, so it is stable on the falling edge after the request
   task automatic expect_reg(input logic [15:0] addr, input logic [63:0] exp,
                             input string name);
      @(negedge clk);
      mmio_rd_en   = 1'b1;
      mmio_rd_addr = addr;
      @(negedge clk);
      mmio_rd_en = 1'b0;
      assert (mmio_rd_valid) else report_violation("mmio_rd_valid missing after mmio_rd_en");
      assert (mmio_rd_data === exp) else report_mismatch(name, exp, mmio_rd_data);
   endtask

   // ====================
   // Processor driver
   // ====================

   task automatic cpu_read(input logic [1:0] seg, input logic [61:0] ofs,
                           output logic [511:0] got);
      logic [511:0] exp_line;
      int           r_go;
      int           r_en;
      int           w_go;
      int           w_en;
      int           n;
      @(negedge clk);
      while (!ready) @(negedge clk);
      exp_addr    = xlate(seg, ofs);
      exp_line    = host_mem[line_index(exp_addr)];
      op_is_write = 1'b0;
      r_go = rd_go_cnt;
      r_en = rd_en_cnt;
      w_go = wr_go_cnt;
      w_en = wr_en_cnt;
      op       = cpu_pkg::op_read;
      cpu_addr = {seg, ofs};
      @(negedge clk);
      op   = cpu_pkg::op_none;
      busy = 1'b1;
      while (!rd_valid) @(negedge clk);
      // Sixteen words arrive back to back with word 0 from the low end of the line
      for (n = 0; n < 16; n++) begin
         assert (rd_valid) else report_violation("rd_valid dropped inside the 16-word burst");
         assert (cpu_rdata === exp_line[32*n +: 32])
            else report_mismatch("cpu_rdata", exp_line[32*n +: 32], cpu_rdata);
         got[32*n +: 32] = cpu_rdata;
         @(negedge clk);
      end
      assert (!rd_valid) else report_violation("rd_valid stayed high after 16 words");
      assert (tx_done) else report_violation("tx_done did not follow the last read word");
      assert (rd_go_cnt - r_go == 1) else report_mismatch("dma_rd_go count", 1, rd_go_cnt - r_go);
      assert (rd_en_cnt - r_en == 1) else report_mismatch("dma_rd_en count", 1, rd_en_cnt - r_en);
      assert (wr_go_cnt == w_go && wr_en_cnt == w_en)
         else report_violation("a read started a DMA write");
   endtask

   task automatic cpu_write(input logic [1:0] seg, input logic [61:0] ofs,
                            input logic [511:0] data);
      int w_go;
      int w_en;
      int done0;
      int n;
      @(negedge clk);
      while (!ready) @(negedge clk);
      exp_addr    = xlate(seg, ofs);
      op_is_write = 1'b1;
      w_go  = wr_go_cnt;
      w_en  = wr_en_cnt;
      done0 = tx_done_cnt;
      op        = cpu_pkg::op_write;
      cpu_addr  = {seg, ofs};
      cpu_wdata = data[31:0];
      for (n = 1; n < 16; n++) begin
         @(negedge clk);
         op        = cpu_pkg::op_none;
         busy      = 1'b1;
         cpu_wdata = data[32*n +: 32];
      end
      @(negedge clk);
      while (tx_done_cnt == done0) @(negedge clk);
      assert (wr_line_seen === data) else report_mismatch("dma_wr_data", data, wr_line_seen);
      assert (wr_go_cnt - w_go == 1) else report_mismatch("dma_wr_go count", 1, wr_go_cnt - w_go);
      assert (wr_en_cnt - w_en == 1) else report_mismatch("dma_wr_en count", 1, wr_en_cnt - w_en);
   endtask

   // ====================
   // Protocol monitor
   // ====================

   // Samples on the rising edge after every DUT output has settled
   // It also forms the capture side of the DMA model that the driver below acts on
   always @(posedge clk) begin
      if (rst_n) begin
         if (!go_written) begin
            assert (!ready) else report_violation("ready rose before go was written");
         end
         assert (!(busy && ready && !tx_done)) else report_violation("ready high mid-transfer");
         if (dma_rd_go || dma_wr_go) begin
            assert (dma_addr === exp_addr) else report_mismatch("dma_addr", exp_addr, dma_addr);
         end
         if (dma_rd_go) begin
            rd_go_cnt++;
            rd_go_seen = 1'b1;
         end
         if (dma_wr_go) begin
            wr_go_cnt++;
            wr_go_seen = 1'b1;
         end
         if (dma_rd_en) begin
            assert (!dma_empty) else report_violation("dma_rd_en pulsed while dma_empty was high");
            assert (rd_go_cnt == rd_en_cnt + 1)
               else report_violation("dma_rd_en came without a preceding dma_rd_go");
            rd_en_cnt++;
            rd_en_seen = 1'b1;
         end
         if (dma_wr_en) begin
            assert (!dma_full) else report_violation("dma_wr_en pulsed while dma_full was high");
            assert (wr_go_cnt == wr_en_cnt + 1)
               else report_violation("dma_wr_en came without a preceding dma_wr_go");
            wr_en_cnt++;
            wr_en_seen   = 1'b1;
            wr_line_seen = dma_wr_data;
            host_mem[line_index(dma_addr)] = dma_wr_data;
         end
         if (tx_done) begin
            if (op_is_write) begin
               assert (dma_wr_done) else report_violation("tx_done came before dma_wr_done");
            end
            tx_done_cnt++;
            busy = 1'b0;
         end
      end
   end

   // ====================
   // DMA model
   // ====================

   // Drives empty, full and done on the falling edge with random delays of 0 to 7 cycles
   always @(negedge clk) begin
      if (rd_go_seen) begin
         rd_go_seen  = 1'b0;
         dma_rd_data = host_mem[line_index(dma_addr)];
         empty_wait  = $random(seed) & 7;
         rd_pending  = 1'b1;
      end
      // One line per transfer, so the channel empties again after the enable
      if (rd_en_seen) begin
         rd_en_seen = 1'b0;
         rd_pending = 1'b0;
         dma_empty  = 1'b1;
      end
      if (rd_pending && dma_empty) begin
         if (empty_wait == 0) dma_empty = 1'b0;
         else empty_wait = empty_wait - 1;
      end
      if (wr_go_seen) begin
         wr_go_seen  = 1'b0;
         dma_wr_done = 1'b0;
         full_wait   = $random(seed) & 7;
         wr_pending  = 1'b1;
      end
      if (wr_en_seen) begin
         wr_en_seen   = 1'b0;
         wr_pending   = 1'b0;
         dma_full     = 1'b1;
         done_wait    = $random(seed) & 7;
         done_pending = 1'b1;
      end
      if (wr_pending && dma_full) begin
         if (full_wait == 0) dma_full = 1'b0;
         else full_wait = full_wait - 1;
      end
      if (done_pending) begin
         if (done_wait == 0) begin
            dma_wr_done  = 1'b1;
            done_pending = 1'b0;
         end else begin
            done_wait = done_wait - 1;
         end
      end
   end

   // About 24 operations under 60 cycles each plus MMIO setup
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         report_violation("timeout, the test sequence did not finish in time");
      end
   end

   // ====================
   // Test sequence
   // ====================

   initial begin
      seed = 32'ha069_e8ce;
      clk = 1'b0;
      rst_n = 1'b0;
      mmio_wr_en = 1'b0;
      mmio_wr_addr = '0;
      mmio_wr_data = '0;
      mmio_rd_en = 1'b0;
      mmio_rd_addr = '0;
      op = cpu_pkg::op_none;
      cpu_addr = '0;
      cpu_wdata = '0;
      dma_rd_data = '0;
      dma_empty = 1'b1;
      dma_full = 1'b1;
      dma_wr_done = 1'b0;
      exp_addr = '0;
      wr_line_seen = '0;
      for (i = 0; i < MEM_LINES; i++) begin
         for (k = 0; k < 16; k++) host_mem[i][32*k +: 32] = $random(seed);
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Register file readback with full-width values and unmapped addresses
      expect_reg(`AFU_MMIO_DONE, 64'd0, "mmio DONE");
      for (i = 0; i < 4; i++) begin
         rd_word = {$random(seed), $random(seed)};
         mmio_write(16'(i), rd_word);
         expect_reg(16'(i), rd_word, "mmio BASE");
      end
      expect_reg(16'd6, 64'd0, "mmio unmapped");
      expect_reg(16'hbeef, 64'd0, "mmio unmapped");

      // Working bases sit in disjoint 16 KiB regions and are not line aligned
      for (i = 0; i < 4; i++) begin
         seg_base[i] = 64'(i * 16384 + ($random(seed) & 63) * 64 + ($random(seed) & 63));
         mmio_write(16'(i), seg_base[i]);
         expect_reg(16'(i), seg_base[i], "mmio BASE");
      end
      go_written = 1'b1;
      mmio_write(`AFU_MMIO_GO, 64'd1);
      expect_reg(`AFU_MMIO_GO, 64'd1, "mmio GO");

      // Copy a line from each segment into the segment two away
      for (round = 0; round < 3; round++) begin
         for (s = 0; s < 4; s++) begin
            off = 62'($random(seed) & 32'h1fff);
            cpu_read(2'(s), off, line);
            cpu_write(2'(s ^ 2), off, line);
            assert (host_mem[line_index(xlate(2'(s ^ 2), off))] ===
                    host_mem[line_index(xlate(2'(s), off))])
               else report_mismatch("host line", host_mem[line_index(xlate(2'(s), off))],
                                    host_mem[line_index(xlate(2'(s ^ 2), off))]);
            if (round == 0 && s == 0) expect_reg(`AFU_MMIO_DONE, 64'd1, "mmio DONE");
         end
      end

      repeat (4) @(negedge clk);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/afu.sv
// AFU top level; every DMA transfer is one cacheline so no size ports exist
`timescale 1ns/1ps
`default_nettype none

`include "afu_settings.svh"

module afu (
   input  wire logic                                         clk,
   input  wire logic                                         rst_n,
   // MMIO port from the host
   input  wire logic                                         mmio_wr_en,
   input  wire logic [`AFU_MMIO_ADDR_WIDTH-1:0]              mmio_wr_addr,
   input  wire host_pkg::host_addr_t                         mmio_wr_data,
   input  wire logic                                         mmio_rd_en,
   input  wire logic [`AFU_MMIO_ADDR_WIDTH-1:0]              mmio_rd_addr,
   output host_pkg::host_addr_t                              mmio_rd_data,
   output logic                                              mmio_rd_valid,
   // Processor port
   input  wire cpu_pkg::mem_op_t                             op,
   input  wire host_pkg::host_addr_t                         cpu_addr,
   input  wire cpu_pkg::word_t                               cpu_wdata,
   output logic                                              ready,
   output cpu_pkg::word_t                                    cpu_rdata,
   output logic                                              rd_valid,
   output logic                                              tx_done,
   // DMA port toward the host engine
   input  wire logic [`AFU_LINE_WORDS*`AFU_WORD_WIDTH-1:0]   dma_rd_data,
   input  wire logic                                         dma_empty,
   input  wire logic                                         dma_full,
   input  wire logic                                         dma_wr_done,
   output host_pkg::host_addr_t                              dma_addr,
   output logic                                              dma_rd_go,
   output logic                                              dma_rd_en,
   output logic                                              dma_wr_go,
   output logic                                              dma_wr_en,
   output logic [`AFU_LINE_WORDS*`AFU_WORD_WIDTH-1:0]        dma_wr_data
);

   host_pkg::host_addr_t base_s0;
   host_pkg::host_addr_t base_s1;
   host_pkg::host_addr_t base_s2;
   host_pkg::host_addr_t base_s3;
   host_pkg::host_addr_t final_addr;
   logic                 go;
   // Lines in the controller's word view that travel flat on the DMA ports
   host_pkg::cl_t        rd_line;
   host_pkg::cl_t        wr_line;

   assign rd_line.flat = dma_rd_data;
   assign dma_wr_data  = wr_line.flat;

   // ====================
   // Register file
   // ====================

   // DONE mirrors the DMA write done level directly
   mmio_regs mmio_regs0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .mmio_wr_en    (mmio_wr_en),
      .mmio_wr_addr  (mmio_wr_addr),
      .mmio_wr_data  (mmio_wr_data),
      .mmio_rd_en    (mmio_rd_en),
      .mmio_rd_addr  (mmio_rd_addr),
      .done          (dma_wr_done),
      .mmio_rd_data  (mmio_rd_data),
      .mmio_rd_valid (mmio_rd_valid),
      .base_s0       (base_s0),
      .base_s1       (base_s1),
      .base_s2       (base_s2),
      .base_s3       (base_s3),
      .go            (go)
   );

   // ====================
   // Translation and control
   // ====================

   addr_tr_unit atu0 (
      .virtual_addr      (cpu_addr),
      .base_address_s0   (base_s0),
      .base_address_s1   (base_s1),
      .base_address_s2   (base_s2),
      .base_address_s3   (base_s3),
      .corrected_address (final_addr)
   );

   // The DMA reports empty and full while the controller takes ready levels
   mem_ctrl mem_ctrl0 (
      .clk                       (clk),
      .rst_n                     (rst_n),
      .host_init                 (go),
      .host_rd_ready             (~dma_empty),
      .host_wr_ready             (~dma_full),
      .host_wr_completed         (dma_wr_done),
      .op                        (op),
      .host_addr_in              (final_addr),
      .common_data_bus_read_in   (cpu_wdata),
      .host_data_bus_read_in     (rd_line),
      .common_data_bus_write_out (cpu_rdata),
      .host_data_bus_write_out   (wr_line),
      .host_addr                 (dma_addr),
      .ready                     (ready),
      .tx_done                   (tx_done),
      .rd_valid                  (rd_valid),
      .host_re                   (dma_rd_en),
      .host_we                   (dma_wr_en),
      .host_rgo                  (dma_rd_go),
      .host_wgo                  (dma_wr_go)
   );

endmodule

`default_nettype wire

//--- rtl/mem_ctrl.sv
// One-line DMA sequencer; write words must arrive on back-to-back cycles and go is never revoked
`timescale 1ns/1ps
`default_nettype none

`include "afu_settings.svh"

module mem_ctrl (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 host_init,
   input  wire logic                 host_rd_ready,
   input  wire logic                 host_wr_ready,
   input  wire logic                 host_wr_completed,
   input  wire cpu_pkg::mem_op_t     op,
   input  wire host_pkg::host_addr_t host_addr_in,
   input  wire cpu_pkg::word_t       common_data_bus_read_in,
   input  wire host_pkg::cl_t        host_data_bus_read_in,
   output cpu_pkg::word_t            common_data_bus_write_out,
   output host_pkg::cl_t             host_data_bus_write_out,
   output host_pkg::host_addr_t      host_addr,
   output logic                      ready,
   output logic                      tx_done,
   output logic                      rd_valid,
   output logic                      host_re,
   output logic                      host_we,
   output logic                      host_rgo,
   output logic                      host_wgo
);

   // Word counter covers one cacheline
   localparam int CNT_W = $clog2(`AFU_LINE_WORDS);
   localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`AFU_LINE_WORDS - 1);

   // ====================
   // State encoding
   // ====================

   typedef enum logic [3:0] {
      S_IDLE,      // waiting for software go
      S_READY,     // accepting processor operations
      S_RD_GO,     // start pulse for the DMA read
      S_RD_WAIT,   // waiting for the read line
      S_RD_STREAM, // returning words to the processor
      S_WR_GATHER, // collecting words 1 to 15
      S_WR_GO,     // start pulse for the DMA write
      S_WR_SPACE,  // waiting for room in the write channel
      S_WR_DONE    // waiting for the host to finish the write
   } state_t;

   state_t           state_q;
   state_t           state_d;
   logic [CNT_W-1:0] cnt_q;
   logic             rd_done_q;
   logic             accept_rd;
   logic             accept_wr;
   logic             last_word;

   // Shared line buffer for both directions
   host_pkg::cl_t        line_q;
   // Translated address held for the whole transfer
   host_pkg::host_addr_t addr_q;

   // An operation is taken only while ready is shown
   assign accept_rd = (state_q == S_READY) && (op == cpu_pkg::op_read);
   assign accept_wr = (state_q == S_READY) && (op == cpu_pkg::op_write);
   assign last_word = (cnt_q == LAST_WORD);

   // ====================
   // Next state
   // ====================

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (host_init) state_d = S_READY;
         end
         S_READY: begin
            if (accept_rd) begin
               state_d = S_RD_GO;
            end else if (accept_wr) begin
               state_d = S_WR_GATHER;
            end
         end
         S_RD_GO:     state_d = S_RD_WAIT;
         S_RD_WAIT: begin
            // Empty back-pressure only stalls here
            if (host_rd_ready) state_d = S_RD_STREAM;
         end
         S_RD_STREAM: begin
            if (last_word) state_d = S_READY;
         end
         S_WR_GATHER: begin
            if (last_word) state_d = S_WR_GO;
         end
         S_WR_GO:     state_d = S_WR_SPACE;
         S_WR_SPACE: begin
            // Full back-pressure only stalls here
            if (host_wr_ready) state_d = S_WR_DONE;
         end
         S_WR_DONE: begin
            if (host_wr_completed) state_d = S_READY;
         end
         default:     state_d = S_IDLE;
      endcase
   end

   // ====================
   // Control registers
   // ====================

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q   <= S_IDLE;
         cnt_q     <= '0;
         rd_done_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         // Marks the cycle right after the last streamed word
         rd_done_q <= (state_q == S_RD_STREAM) && last_word;
         // Word 0 of a write is taken at accept, so gathering starts at 1
         if (accept_wr) begin
            cnt_q <= CNT_W'(1);
         end else if ((state_q == S_RD_STREAM) || (state_q == S_WR_GATHER)) begin
            // Wraps back to zero after the last word
            cnt_q <= cnt_q + CNT_W'(1);
         end
      end
   end

   // ====================
   // Line buffer and address
   // ====================

   always_ff @(posedge clk) begin
      if (accept_rd || accept_wr) begin
         addr_q <= host_addr_in;
      end
      if (accept_wr) begin
         line_q.words[0] <= common_data_bus_read_in;
      end else if (state_q == S_WR_GATHER) begin
         line_q.words[cnt_q] <= common_data_bus_read_in;
      end else if (host_re) begin
         // Whole line lands at once from the DMA
         line_q <= host_data_bus_read_in;
      end
   end

   // ====================
   // Outputs
   // ====================

   assign ready    = (state_q == S_READY);
   assign rd_valid = (state_q == S_RD_STREAM);
   assign host_rgo = (state_q == S_RD_GO);
   assign host_wgo = (state_q == S_WR_GO);

   // Enables are single pulses since the state leaves on the same edge
   assign host_re = (state_q == S_RD_WAIT) && host_rd_ready;
   assign host_we = (state_q == S_WR_SPACE) && host_wr_ready;

   // Reads finish a cycle after the stream, writes when the host reports done
   assign tx_done = rd_done_q || ((state_q == S_WR_DONE) && host_wr_completed);

   assign common_data_bus_write_out = line_q.words[cnt_q];
   assign host_data_bus_write_out   = line_q;
   assign host_addr                 = addr_q;

endmodule

`default_nettype wire

//--- rtl/addr_tr_unit.sv
// Combinational segment translation; the offset add wraps silently if base plus offset overflows
`timescale 1ns/1ps
`default_nettype none

`include "afu_settings.svh"

module addr_tr_unit (
   input  wire host_pkg::host_addr_t virtual_addr,
   input  wire host_pkg::host_addr_t base_address_s0,
   input  wire host_pkg::host_addr_t base_address_s1,
   input  wire host_pkg::host_addr_t base_address_s2,
   input  wire host_pkg::host_addr_t base_address_s3,
   output host_pkg::host_addr_t      corrected_address
);

   // Segment number taken from the top two bits of the virtual address
   logic [1:0]           seg;
   // Offset within the segment zero extended back to full width
   host_pkg::host_addr_t offset;
   // Base of the selected segment
   host_pkg::host_addr_t seg_base;

   // ====================
   // Field split
   // ====================

   assign seg    = virtual_addr[`AFU_SEG_MSB -: 2];
   assign offset = {2'b00, virtual_addr[`AFU_SEG_MSB-2:0]};

   // ====================
   // Base select and add
   // ====================

   always_comb begin
      case (seg)
         2'd0:    seg_base = base_address_s0;
         2'd1:    seg_base = base_address_s1;
         2'd2:    seg_base = base_address_s2;
         default: seg_base = base_address_s3;
      endcase
   end

   // The controller samples this sum at accept
   assign corrected_address = seg_base + offset;

endmodule

`default_nettype wire

//--- rtl/mmio_regs.sv
// MMIO registers with single-cycle read responses; unmapped reads return zero, writes are ignored
`timescale 1ns/1ps
`default_nettype none

`include "afu_settings.svh"

module mmio_regs (
   input  wire logic                             clk,
   input  wire logic                             rst_n,
   input  wire logic                             mmio_wr_en,
   input  wire logic [`AFU_MMIO_ADDR_WIDTH-1:0]  mmio_wr_addr,
   input  wire host_pkg::host_addr_t             mmio_wr_data,
   input  wire logic                             mmio_rd_en,
   input  wire logic [`AFU_MMIO_ADDR_WIDTH-1:0]  mmio_rd_addr,
   input  wire logic                             done,
   output host_pkg::host_addr_t                  mmio_rd_data,
   output logic                                  mmio_rd_valid,
   output host_pkg::host_addr_t                  base_s0,
   output host_pkg::host_addr_t                  base_s1,
   output host_pkg::host_addr_t                  base_s2,
   output host_pkg::host_addr_t                  base_s3,
   output logic                                  go
);

   // ====================
   // Register writes
   // ====================

   // Reset clears all four segment bases and the go bit
   // A write becomes visible on the following cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         base_s0 <= '0;
         base_s1 <= '0;
         base_s2 <= '0;
         base_s3 <= '0;
         go      <= 1'b0;
      end else if (mmio_wr_en) begin
         case (mmio_wr_addr)
            `AFU_MMIO_BASE0: base_s0 <= mmio_wr_data;
            `AFU_MMIO_BASE1: base_s1 <= mmio_wr_data;
            `AFU_MMIO_BASE2: base_s2 <= mmio_wr_data;
            `AFU_MMIO_BASE3: base_s3 <= mmio_wr_data;
            // Only bit 0 of the written value matters for go
            `AFU_MMIO_GO:    go      <= mmio_wr_data[0];
            default: ;
         endcase
      end
   end

   // ====================
   // Register reads
   // ====================

   // The valid strobe follows mmio_rd_en by one cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mmio_rd_valid <= 1'b0;
      end else begin
         mmio_rd_valid <= mmio_rd_en;
      end
   end

   // Read data is captured with the request and holds until the next read
   // DONE reports the live level of the done input at the time of the read
   always_ff @(posedge clk) begin
      if (mmio_rd_en) begin
         case (mmio_rd_addr)
            `AFU_MMIO_BASE0: mmio_rd_data <= base_s0;
            `AFU_MMIO_BASE1: mmio_rd_data <= base_s1;
            `AFU_MMIO_BASE2: mmio_rd_data <= base_s2;
            `AFU_MMIO_BASE3: mmio_rd_data <= base_s3;
            `AFU_MMIO_GO:    mmio_rd_data <= host_pkg::host_addr_t'(go);
            `AFU_MMIO_DONE:  mmio_rd_data <= host_pkg::host_addr_t'(done);
            default:         mmio_rd_data <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/cpu_pkg.sv
// Processor side types; only single word reads and writes exist, no byte enables
`default_nettype none

`include "afu_settings.svh"

package cpu_pkg;

   // ====================
   // Memory operations
   // ====================

   // Operation code presented by the processor
   // op_none is the idle value between operations
   // A read or write is only taken while the controller shows ready
   typedef enum logic [1:0] {
      op_none  = 2'b00,
      op_read  = 2'b01,
      op_write = 2'b10
   } mem_op_t;

   // One processor data word
   typedef logic [`AFU_WORD_WIDTH-1:0] word_t;

endpackage

`default_nettype wire

//--- rtl/host_pkg.sv
// Host side types; the cacheline layout assumes word 0 sits in the least significant bits
`default_nettype none

`include "afu_settings.svh"

package host_pkg;

   // ====================
   // Host addressing
   // ====================

   // A host byte address as seen by the DMA engine
   // Segment bases and translated addresses use the same type
   typedef logic [`AFU_ADDR_WIDTH-1:0] host_addr_t;

   // ====================
   // Cacheline
   // ====================

   // One cacheline decoded two ways
   // The DMA engine moves the flat view as a single 512-bit value
   // The memory controller reads and fills it one processor word at a time
   // Word 0 maps onto the lowest 32 bits of the flat view
   typedef union packed {
      // Whole line as carried on the DMA data ports
      logic [`AFU_LINE_WORDS*`AFU_WORD_WIDTH-1:0] flat;
      // Same bits split into processor words
      logic [`AFU_LINE_WORDS-1:0][`AFU_WORD_WIDTH-1:0] words;
   } cl_t;

endpackage

`default_nettype wire

//--- rtl/afu_settings.svh
// Widths and MMIO map shared by the packages and RTL; a cacheline must equal LINE_WORDS words
`ifndef AFU_SETTINGS_SVH
`define AFU_SETTINGS_SVH

// ====================
// Datapath widths
// ====================

// Processor data word width in bits
`define AFU_WORD_WIDTH 32

// Processor words per host cacheline, giving a 512-bit line
`define AFU_LINE_WORDS 16

// Width of both virtual and host byte addresses
`define AFU_ADDR_WIDTH 64

// Top bit of the two-bit segment field in a virtual address
// The offset occupies every bit below the segment field
`define AFU_SEG_MSB 63

// ====================
// MMIO register map
// ====================

// Width of the MMIO word address
`define AFU_MMIO_ADDR_WIDTH 16

// Segment base registers, one per host segment
`define AFU_MMIO_BASE0 16'd0
`define AFU_MMIO_BASE1 16'd1
`define AFU_MMIO_BASE2 16'd2
`define AFU_MMIO_BASE3 16'd3

// Go is written by software, done is read only
`define AFU_MMIO_GO   16'd4
`define AFU_MMIO_DONE 16'd5

`endif
